//--- sat_lit_pkg.sv
package sat_lit_pkg;

    // ********************
    // literal word layout
    // ********************

    localparam int LIT_W = 3;

    // base to cell. neg is sampled only on a write strobe,
    // assigned/val carry the variable state the rest of the time.
    typedef struct packed {
        logic neg;      // literal polarity, 1 for a negated literal.
        logic assigned; // variable has a value.
        logic val;      // variable value.
    } lit_in_t;

    // cell to base.
    typedef struct packed {
        logic rsvd;      // always zero.
        logic imp_valid; // this literal is implied.
        logic imp_val;   // value the variable must take.
    } lit_out_t;

    // one bus word, decoded by direction.
    typedef union packed {
        lit_in_t  in;
        lit_out_t out;
    } lit_word_u;

    // ********************
    // variable value codes
    // ********************

    localparam logic VAL_FALSE = 1'b0;
    localparam logic VAL_TRUE  = 1'b1;

endpackage

//--- sat_clause_pkg.sv
package sat_clause_pkg;

    // ********************
    // free literal count
    // ********************

    localparam int FREE_W = 2;

    // saturating codes, anything above one reads as many.
    localparam logic [FREE_W-1:0] FREE_NONE = 2'd0;
    localparam logic [FREE_W-1:0] FREE_ONE  = 2'd1;
    localparam logic [FREE_W-1:0] FREE_MANY = 2'd2;

    // add two counts and clamp at FREE_MANY.
    function automatic logic [FREE_W-1:0] free_sat_add(
        input logic [FREE_W-1:0] a,
        input logic [FREE_W-1:0] b
    );
        logic [FREE_W:0] sum;
        sum = a + b;
        if (sum >= FREE_MANY) begin
            return FREE_MANY;
        end
        return sum[FREE_W-1:0];
    endfunction

endpackage

//--- lit_group.sv
`timescale 1ns/1ps

module lit_group #(
    parameter int GROUP_LITS = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   wr_i,
    input  sat_lit_pkg::lit_word_u [GROUP_LITS-1:0] lits_i,
    output sat_lit_pkg::lit_word_u [GROUP_LITS-1:0] lits_o,
    input  logic                                   imp_drv_i,
    output logic [sat_clause_pkg::FREE_W-1:0]      free_cnt_o,
    output logic                                   sat_o
);

    logic [GROUP_LITS-1:0] neg_r;    // stored polarity per literal.
    logic [GROUP_LITS-1:0] true_val; // value that makes each literal true.
    logic [GROUP_LITS-1:0] lit_free;
    logic [GROUP_LITS-1:0] lit_true;
    logic [sat_clause_pkg::FREE_W-1:0] free_cnt;

    // ********************
    // polarity storage
    // ********************

    always_ff @(posedge clk) begin
        if (!rst) begin
            neg_r <= '0;
        end else if (wr_i) begin
            for (int i = 0; i < GROUP_LITS; i++) begin
                neg_r[i] <= lits_i[i].in.neg;
            end
        end
    end

    // ********************
    // literal evaluation
    // ********************

    always_comb begin
        for (int i = 0; i < GROUP_LITS; i++) begin
            true_val[i] = neg_r[i] ? sat_lit_pkg::VAL_FALSE : sat_lit_pkg::VAL_TRUE;
            lit_free[i] = !lits_i[i].in.assigned;
            lit_true[i] = lits_i[i].in.assigned && (lits_i[i].in.val == true_val[i]);
        end
    end

    // free count clamps at two, enough for the unit check.
    always_comb begin
        free_cnt = sat_clause_pkg::FREE_NONE;
        for (int i = 0; i < GROUP_LITS; i++) begin
            if (lit_free[i]) begin
                free_cnt = sat_clause_pkg::free_sat_add(free_cnt, sat_clause_pkg::FREE_ONE);
            end
        end
    end

    assign free_cnt_o = free_cnt;
    assign sat_o      = |lit_true;

    // ********************
    // implication drive
    // ********************

    // only the free literal gets a word while the clause is unit.
    always_comb begin
        for (int i = 0; i < GROUP_LITS; i++) begin
            lits_o[i] = '0;
            if (imp_drv_i && lit_free[i]) begin
                lits_o[i].out.imp_valid = 1'b1;
                lits_o[i].out.imp_val   = true_val[i];
            end
        end
    end

endmodule

//--- clause_ctrl.sv
`timescale 1ns/1ps

module clause_ctrl #(
    parameter int LEN_W = 5
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wr_i,
    input  logic [sat_clause_pkg::FREE_W-1:0] free_cnt_lo_i,
    input  logic [sat_clause_pkg::FREE_W-1:0] free_cnt_hi_i,
    input  logic                              sat_lo_i,
    input  logic                              sat_hi_i,
    input  logic [LEN_W-1:0]                  clause_len_i,
    input  logic                              apply_impl_i,
    input  logic                              apply_bkt_i,
    output logic                              imp_drv_o,
    output logic                              conflict_o,
    output logic [LEN_W-1:0]                  clause_len_o
);

    logic [sat_clause_pkg::FREE_W-1:0] free_total;
    logic                              clause_sat;
    logic                              reason;     // clause is the reason of an implication.
    logic                              need_clear; // reason clause has seen a conflict.
    logic [LEN_W-1:0]                  clause_len_r;

    // ********************
    // clause evaluation
    // ********************

    assign free_total = sat_clause_pkg::free_sat_add(free_cnt_lo_i, free_cnt_hi_i);
    assign clause_sat = sat_lo_i | sat_hi_i;

    // unit clause drives its last literal.
    assign imp_drv_o  = !clause_sat && (free_total == sat_clause_pkg::FREE_ONE);
    assign conflict_o = !clause_sat && (free_total == sat_clause_pkg::FREE_NONE);

    // ********************
    // reason tracking
    // ********************

    always_ff @(posedge clk) begin
        if (!rst) begin
            reason <= 1'b0;
        end else if (apply_impl_i && imp_drv_o) begin
            reason <= 1'b1;
        end else if (apply_bkt_i && need_clear) begin
            reason <= 1'b0; // backtrack past the implied literal.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            need_clear <= 1'b0;
        end else if (reason && conflict_o) begin
            need_clear <= 1'b1;
        end else if (!reason) begin
            need_clear <= 1'b0;
        end
    end

    // ********************
    // clause length
    // ********************

    always_ff @(posedge clk) begin
        if (!rst) begin
            clause_len_r <= '0;
        end else if (wr_i) begin
            clause_len_r <= clause_len_i;
        end
    end

    // a reason clause is kept out of the learnt-clause search.
    assign clause_len_o = reason ? '0 : clause_len_r;

endmodule

//--- clause_cell.sv
`timescale 1ns/1ps

module clause_cell #(
    parameter int NUM_LITS = 8,
    parameter int LEN_W    = 5
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wr_i,
    input  sat_lit_pkg::lit_word_u [NUM_LITS-1:0] var_value_i,
    output sat_lit_pkg::lit_word_u [NUM_LITS-1:0] var_value_o,
    input  logic [LEN_W-1:0]                     clause_len_i,
    output logic [LEN_W-1:0]                     clause_len_o,
    input  logic                                 apply_impl_i,
    input  logic                                 apply_bkt_i,
    output logic                                 imp_o,
    output logic                                 conflict_o
);

    localparam int GROUP_LITS = NUM_LITS / 2;

    logic [sat_clause_pkg::FREE_W-1:0] free_cnt_lo;
    logic [sat_clause_pkg::FREE_W-1:0] free_cnt_hi;
    logic                              sat_lo;
    logic                              sat_hi;
    logic                              imp_drv;

    // ********************
    // literal halves
    // ********************

    lit_group #(
        .GROUP_LITS (GROUP_LITS)
    ) lit_group_lo (
        .clk        (clk),
        .rst        (rst),
        .wr_i       (wr_i),
        .lits_i     (var_value_i[GROUP_LITS-1:0]),
        .lits_o     (var_value_o[GROUP_LITS-1:0]),
        .imp_drv_i  (imp_drv),
        .free_cnt_o (free_cnt_lo),
        .sat_o      (sat_lo)
    );

    lit_group #(
        .GROUP_LITS (GROUP_LITS)
    ) lit_group_hi (
        .clk        (clk),
        .rst        (rst),
        .wr_i       (wr_i),
        .lits_i     (var_value_i[NUM_LITS-1:GROUP_LITS]),
        .lits_o     (var_value_o[NUM_LITS-1:GROUP_LITS]),
        .imp_drv_i  (imp_drv),
        .free_cnt_o (free_cnt_hi),
        .sat_o      (sat_hi)
    );

    // ********************
    // clause controller
    // ********************

    clause_ctrl #(
        .LEN_W (LEN_W)
    ) clause_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .wr_i          (wr_i),
        .free_cnt_lo_i (free_cnt_lo),
        .free_cnt_hi_i (free_cnt_hi),
        .sat_lo_i      (sat_lo),
        .sat_hi_i      (sat_hi),
        .clause_len_i  (clause_len_i),
        .apply_impl_i  (apply_impl_i),
        .apply_bkt_i   (apply_bkt_i),
        .imp_drv_o     (imp_drv),
        .conflict_o    (conflict_o),
        .clause_len_o  (clause_len_o)
    );

    assign imp_o = imp_drv;

endmodule

//--- clause_cell_assert.sv
`timescale 1ns/1ps

module clause_cell_assert #(
    parameter int LEN_W = 5
) (
    input logic             clk,
    input logic             rst,
    input logic             apply_impl_i,
    input logic             imp_drv_i,
    input logic             conflict_i,
    input logic [LEN_W-1:0] len_shown_i
);

    // a unit clause has one free literal, a conflicting one has none.
    imp_conf_excl: assert property (@(posedge clk) disable iff (!rst)
        !(imp_drv_i && conflict_i))
        else $error("imp_drv_o and conflict_o high together");

    len_hidden: assert property (@(posedge clk) disable iff (!rst)
        (apply_impl_i && imp_drv_i) |=> (len_shown_i == '0))
        else $error("clause length visible after an applied implication");

endmodule

bind clause_ctrl clause_cell_assert #(
    .LEN_W (LEN_W)
) clause_cell_assert_inst (
    .clk          (clk),
    .rst          (rst),
    .apply_impl_i (apply_impl_i),
    .imp_drv_i    (imp_drv_o),
    .conflict_i   (conflict_o),
    .len_shown_i  (clause_len_o)
);

//--- tb_clause_cell.sv
`timescale 1ns/1ps

module tb_clause_cell;

    localparam int NUM_LITS = 8;
    localparam int LEN_W    = 5;
    localparam int IDX_W    = $clog2(NUM_LITS);
    localparam int BUS_W    = sat_lit_pkg::LIT_W * NUM_LITS;
    localparam int WAIT_MAX = 64;   // cycles any single wait may take.
    localparam int RUN_MAX  = 2000; // cycles for the whole run.

    logic                                  clk;
    logic                                  rst;
    logic                                  wr_i;
    sat_lit_pkg::lit_word_u [NUM_LITS-1:0] var_value_i;
    sat_lit_pkg::lit_word_u [NUM_LITS-1:0] var_value_o;
    logic [LEN_W-1:0]                      clause_len_i;
    logic [LEN_W-1:0]                      clause_len_o;
    logic                                  apply_impl_i;
    logic                                  apply_bkt_i;
    logic                                  imp_o;
    logic                                  conflict_o;

    logic [15:0]         lfsr;         // stimulus LFSR state.
    logic [NUM_LITS-1:0] neg_model;    // polarities the DUT should hold.
    logic [LEN_W-1:0]    len_model;
    logic                reason_model;
    logic                clear_model;

    clause_cell #(
        .NUM_LITS (NUM_LITS),
        .LEN_W    (LEN_W)
    ) clause_cell_inst (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (wr_i),
        .var_value_i  (var_value_i),
        .var_value_o  (var_value_o),
        .clause_len_i (clause_len_i),
        .clause_len_o (clause_len_o),
        .apply_impl_i (apply_impl_i),
        .apply_bkt_i  (apply_bkt_i),
        .imp_o        (imp_o),
        .conflict_o   (conflict_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // ********************
    // helpers
    // ********************

    // x^16 + x^14 + x^13 + x^11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[0] ^ state[2] ^ state[3] ^ state[5];
        return {fb, state[15:1]};
    endfunction

    task automatic take_rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    // expected {imp, conflict, outbound words}.
    function automatic logic [BUS_W+1:0] clause_ref(
        input logic [NUM_LITS-1:0]                  neg,
        input sat_lit_pkg::lit_word_u [NUM_LITS-1:0] words
    );
        int                                    n_free;
        logic                                  sat;
        logic                                  imp;
        logic                                  confl;
        sat_lit_pkg::lit_word_u [NUM_LITS-1:0] outw;
        n_free = 0;
        sat    = 1'b0;
        for (int i = 0; i < NUM_LITS; i++) begin
            if (!words[i].in.assigned) begin
                n_free++;
            end else if (words[i].in.val != neg[i]) begin
                sat = 1'b1; // true literal.
            end
        end
        imp   = !sat && (n_free == 1);
        confl = !sat && (n_free == 0);
        outw  = '0;
        for (int i = 0; i < NUM_LITS; i++) begin
            if (imp && !words[i].in.assigned) begin
                outw[i].out.imp_valid = 1'b1;
                outw[i].out.imp_val   = !neg[i];
            end
        end
        return {imp, confl, outw};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_clause(input logic [LEN_W-1:0] len);
        logic [7:0] r;
        for (int i = 0; i < NUM_LITS; i++) begin
            take_rand_bits(1, r);
            var_value_i[i]        = '0;
            var_value_i[i].in.neg = r[0];
        end
        clause_len_i = len;
        wr_i         = 1'b1;
        step_cycle();
        wr_i = 1'b0;
    endtask

    // n_free unassigned literals, the rest false, one made true on want_sat.
    task automatic build_vector(input int n_free, input logic want_sat);
        logic [7:0]          r;
        logic [NUM_LITS-1:0] free_mask;
        int                  placed;
        int                  guard;
        int                  idx;
        logic                found;
        free_mask = '0;
        placed    = 0;
        guard     = 0;
        while (placed < n_free && guard < WAIT_MAX) begin
            take_rand_bits(IDX_W, r);
            if (!free_mask[r[IDX_W-1:0]]) begin
                free_mask[r[IDX_W-1:0]] = 1'b1;
                placed++;
            end
            guard++;
        end
        if (placed < n_free) begin
            abort_run("could not place the free literals of a test vector");
        end
        for (int i = 0; i < NUM_LITS; i++) begin
            take_rand_bits(1, r);
            var_value_i[i].in.neg      = r[0]; // ignored outside a write.
            var_value_i[i].in.assigned = !free_mask[i];
            var_value_i[i].in.val      = neg_model[i];
        end
        take_rand_bits(IDX_W, r);
        found = 1'b0;
        for (int k = 0; k < NUM_LITS; k++) begin
            idx = (int'(r[IDX_W-1:0]) + k) % NUM_LITS;
            if (want_sat && !found && !free_mask[idx]) begin
                var_value_i[idx].in.val = !neg_model[idx];
                found = 1'b1;
            end
        end
    endtask

    // random vectors until imp_o or conflict_o shows up.
    task automatic seek_outcome(input logic want_conflict);
        logic [7:0] r;
        int         tries;
        logic       hit;
        tries = 0;
        hit   = 1'b0;
        while (!hit) begin
            take_rand_bits(2, r);
            build_vector(int'(r[1:0]), 1'b0);
            #17;
            hit = want_conflict ? conflict_o : imp_o;
            step_cycle();
            if (!hit) begin
                tries++;
                if (tries > WAIT_MAX) begin
                    abort_run("timeout while waiting for an implication or conflict");
                end
            end
        end
    endtask

    // ********************
    // compare
    // ********************

    initial begin : compare_proc
        logic [BUS_W+1:0] exp_all;
        logic [LEN_W-1:0] exp_len;
        logic             next_reason;
        logic             next_clear;
        int               reset_cycles;
        reset_cycles = 0;
        forever begin
            @(posedge clk);
            #19;
            if (rst !== 1'b1) begin
                neg_model    = '0;
                len_model    = '0;
                reason_model = 1'b0;
                clear_model  = 1'b0;
                reset_cycles++;
                if (reset_cycles > WAIT_MAX) begin
                    abort_run("reset was never released");
                end
            end else begin
                exp_all = clause_ref(neg_model, var_value_i);
                exp_len = reason_model ? {LEN_W{1'b0}} : len_model; // hidden while a reason.
                check_val("imp_o", 32'(imp_o), 32'(exp_all[BUS_W+1]));
                check_val("conflict_o", 32'(conflict_o), 32'(exp_all[BUS_W]));
                check_val("var_value_o", 32'(var_value_o), 32'(exp_all[BUS_W-1:0]));
                check_val("clause_len_o", 32'(clause_len_o), 32'(exp_len));
                next_reason = reason_model;
                next_clear  = clear_model;
                if (apply_impl_i && exp_all[BUS_W+1]) begin
                    next_reason = 1'b1;
                end else if (apply_bkt_i && clear_model) begin
                    next_reason = 1'b0;
                end
                if (reason_model && exp_all[BUS_W]) begin
                    next_clear = 1'b1;
                end else if (!reason_model) begin
                    next_clear = 1'b0;
                end
                reason_model = next_reason;
                clear_model  = next_clear;
                if (wr_i) begin
                    for (int i = 0; i < NUM_LITS; i++) begin
                        neg_model[i] = var_value_i[i].in.neg;
                    end
                    len_model = clause_len_i;
                end
            end
        end
    end

    initial begin : watchdog_proc
        int cycles;
        cycles = 0;
        while (cycles < RUN_MAX) begin
            @(posedge clk);
            cycles++;
        end
        abort_run("simulation ran past its cycle limit");
    end

    // ********************
    // stimulus
    // ********************

    initial begin : stimulus_proc
        logic [7:0] r;
        rst          = 1'b0;
        wr_i         = 1'b0;
        var_value_i  = '0;
        clause_len_i = '0;
        apply_impl_i = 1'b0;
        apply_bkt_i  = 1'b0;
        lfsr         = 16'd37423;
        step_cycle();
        step_cycle();
        rst = 1'b1;

        write_clause(LEN_W'(NUM_LITS));
        for (int n = 0; n < 4; n++) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < 6; k++) begin
                    build_vector(n, s[0]);
                    step_cycle();
                end
            end
        end

        // one free literal in each half, then one in either half alone.
        build_vector(0, 1'b0);
        var_value_i[1].in.assigned = 1'b0;
        var_value_i[6].in.assigned = 1'b0;
        step_cycle();
        var_value_i[6].in.assigned = 1'b1;
        step_cycle();
        var_value_i[1].in.assigned = 1'b1;
        var_value_i[6].in.assigned = 1'b0;
        step_cycle();

        for (int k = 0; k < 40; k++) begin
            for (int i = 0; i < NUM_LITS; i++) begin
                take_rand_bits(3, r);
                var_value_i[i] = r[2:0];
            end
            step_cycle();
        end

        write_clause(5'd19);
        for (int k = 0; k < 20; k++) begin
            take_rand_bits(2, r);
            build_vector(int'(r[1:0]), r[0] & r[1]);
            step_cycle();
        end

        // reason clause that runs into a conflict, then backtracks.
        seek_outcome(1'b0);
        apply_impl_i = 1'b1;
        step_cycle();
        apply_impl_i = 1'b0;
        build_vector(2, 1'b1);
        step_cycle();
        seek_outcome(1'b1);
        step_cycle();
        build_vector(3, 1'b1);
        apply_bkt_i = 1'b1;
        step_cycle();
        apply_bkt_i = 1'b0;
        step_cycle();
        step_cycle();

        // backtrack with no conflict seen keeps the length hidden.
        seek_outcome(1'b0);
        apply_impl_i = 1'b1;
        step_cycle();
        apply_impl_i = 1'b0;
        build_vector(2, 1'b1);
        step_cycle();
        apply_bkt_i = 1'b1;
        step_cycle();
        apply_bkt_i = 1'b0;
        step_cycle();
        step_cycle();

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- list.f
sat_lit_pkg.sv
sat_clause_pkg.sv
lit_group.sv
clause_ctrl.sv
clause_cell.sv
clause_cell_assert.sv
tb_clause_cell.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run the clause cell testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_clause_cell &&
./obj_dir/Vtb_clause_cell | tee /dev/stderr | grep -qF "Done: no errors" &&
echo "PASS" && exit 0 ||
{ echo "FAIL"; exit 1; }
